//--- Makefile
TOP = tb_frv_asi

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

//--- asi_aes_mix.sv
// AES MixColumn on one column
module asi_aes_mix import asi_pkg::*; (
    input  logic [XLEN-1:0] col,    // Byte 0 is row 0
    input  logic            inv,    // InvMixColumns
    output logic [XLEN-1:0] result
);

    function automatic logic [7:0] xtime(input logic [7:0] a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    logic [7:0] a  [4];             // Column bytes
    logic [7:0] d2 [4];             // 2a
    logic [7:0] d4 [4];             // 4a
    logic [7:0] d8 [4];             // 8a
    logic [7:0] r  [4];

    // Doublings per byte, all other multiples built from these
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            a[i]  = col[8*i +: 8];
            d2[i] = xtime(a[i]);
            d4[i] = xtime(d2[i]);
            d8[i] = xtime(d4[i]);
        end
    end

    // Row i takes its coefficients rotated by i
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            if (inv) begin
                r[i] = (d8[i] ^ d4[i] ^ d2[i])                       // 14
                     ^ (d8[(i+1)%4] ^ d2[(i+1)%4] ^ a[(i+1)%4])       // 11
                     ^ (d8[(i+2)%4] ^ d4[(i+2)%4] ^ a[(i+2)%4])       // 13
                     ^ (d8[(i+3)%4] ^ a[(i+3)%4]);                    // 9
            end else begin
                r[i] = d2[i]                                          // 2
                     ^ (d2[(i+1)%4] ^ a[(i+1)%4])                     // 3
                     ^ a[(i+2)%4]
                     ^ a[(i+3)%4];
            end
        end
    end

    assign result = {r[3], r[2], r[1], r[0]};

endmodule

//--- asi_aes_sbox.sv
// AES S-box by field inversion
module asi_aes_sbox (
    input  logic [7:0] din,
    input  logic       inv,     // Inverse S-box
    output logic [7:0] dout
);

    // ----------------------------------------------------------
    // GF(2^8) arithmetic, modulus 0x11B
    // ----------------------------------------------------------

    function automatic logic [7:0] xtime(input logic [7:0] a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    // Shift-and-add multiply
    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] t;
        p = 8'h00;
        t = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) p = p ^ t;
            t = xtime(t);
        end
        return p;
    endfunction

    // a^254, which is a^-1 and maps 0 to 0
    function automatic logic [7:0] gf_inv(input logic [7:0] a);
        logic [7:0] a3, a7, a15, a127;
        a3   = gf_mul(gf_mul(a, a), a);
        a7   = gf_mul(gf_mul(a3, a3), a);
        a15  = gf_mul(gf_mul(a7, a7), a);
        a127 = gf_mul(gf_mul(gf_mul(gf_mul(a15, a15), gf_mul(a15, a15)),
                             gf_mul(gf_mul(a15, a15), gf_mul(a15, a15))), a7);
        return gf_mul(a127, a127);
    endfunction

    function automatic logic [7:0] rotl8(input logic [7:0] a, input int n);
        return (a << n) | (a >> (8 - n));
    endfunction

    // ----------------------------------------------------------
    // Affine maps
    // ----------------------------------------------------------

    function automatic logic [7:0] affine(input logic [7:0] a);
        return a ^ rotl8(a, 1) ^ rotl8(a, 2) ^ rotl8(a, 3) ^ rotl8(a, 4) ^ 8'h63;
    endfunction

    function automatic logic [7:0] affine_inv(input logic [7:0] a);
        return rotl8(a, 1) ^ rotl8(a, 3) ^ rotl8(a, 6) ^ 8'h05;
    endfunction

    // One inverter shared by both directions
    logic [7:0] inv_in;
    logic [7:0] inv_out;

    assign inv_in  = inv ? affine_inv(din) : din;       // Undo affine first
    assign inv_out = gf_inv(inv_in);
    assign dout    = inv ? inv_out : affine(inv_out);   // Affine last on encrypt

endmodule

//--- asi_aes_sub.sv
// Byte-serial AES SubBytes engine
module asi_aes_sub import asi_pkg::*; (
    input  logic            g_clk,
    input  logic            rst_n,
    input  logic            start,  // Held high for the whole operation
    input  logic            inv,    // Inverse S-box
    input  logic            rot,    // Rotate result left one byte
    input  logic            flush,  // Abandon current operation
    input  logic [XLEN-1:0] rs1,
    output logic            done,   // One-cycle result strobe
    output logic [XLEN-1:0] result
);

    logic [1:0]      byte_cnt;      // Byte presented to the S-box
    logic            busy;          // Bytes 1..3 still to go
    logic            launch;        // First cycle of an operation
    logic            step;          // S-box output is wanted this cycle
    logic            last;
    logic [7:0]      sbox_din;
    logic [7:0]      sbox_dout;
    logic [XLEN-1:0] sub_q;         // Collected substituted bytes

    // start stays high through done, so only launch from idle
    assign launch = start && !busy && !done && !flush;
    assign step   = launch || busy;
    assign last   = (byte_cnt == 2'(AES_SUB_CYCLES - 1));

    assign sbox_din = rs1[8*byte_cnt +: 8];   // Byte 0 first, counter idles at 0

    asi_aes_sbox i_sbox (
        .din  (sbox_din),
        .inv  (inv),
        .dout (sbox_dout)
    );

    // ----------------------------------------------------------
    // Control
    // ----------------------------------------------------------

    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            byte_cnt <= 2'd0;
        end else if (flush) begin
            busy     <= 1'b0;               // Straight back to idle
            done     <= 1'b0;
            byte_cnt <= 2'd0;
        end else begin
            done <= 1'b0;                   // Strobe, one cycle only
            if (step) begin
                byte_cnt <= byte_cnt + 2'd1; // Wraps to 0 after last byte
                busy     <= !last;
                done     <= last;
            end
        end
    end

    // ----------------------------------------------------------
    // Datapath
    // ----------------------------------------------------------

    always_ff @(posedge g_clk) begin
        if (step) sub_q[8*byte_cnt +: 8] <= sbox_dout;
    end

    assign result = rot ? {sub_q[XLEN-9:0], sub_q[XLEN-1:XLEN-8]} : sub_q;

    // Stage must hold the op until done, never re-issue mid-flight
    assert property (@(posedge g_clk) disable iff (!rst_n) busy |-> !$rose(start))
        else $error("asi_aes_sub: start rose while busy");

    // Flush kills a pending strobe
    assert property (@(posedge g_clk) disable iff (!rst_n) flush |=> !done)
        else $error("asi_aes_sub: done after flush");

endmodule

//--- asi_pkg.sv
// Algorithm-specific instruction definitions
package asi_pkg;

    // ----------------------------------------------------------
    // Widths and timing
    // ----------------------------------------------------------

    localparam int XLEN           = 32; // Register width, one word
    localparam int OPW            = 5;  // Micro-op width
    localparam int AES_SUB_CYCLES = 4;  // S-box passes per SubBytes op

    // ----------------------------------------------------------
    // Operation classes, top two micro-op bits
    // ----------------------------------------------------------

    // Class 00 left unused so a zeroed micro-op is illegal
    localparam logic [1:0] ASI_AES  = 2'b01;
    localparam logic [1:0] ASI_SHA2 = 2'b10;
    localparam logic [1:0] ASI_SHA3 = 2'b11;

    // ----------------------------------------------------------
    // Exact micro-op codes
    // ----------------------------------------------------------

    // AES, bit 2 picks mix over sub
    // Sub: bit 1 inverse, bit 0 byte rotate
    localparam logic [OPW-1:0] ASI_AESSUB_ENC    = 5'b01_0_00;
    localparam logic [OPW-1:0] ASI_AESSUB_ENCROT = 5'b01_0_01;
    localparam logic [OPW-1:0] ASI_AESSUB_DEC    = 5'b01_0_10;
    localparam logic [OPW-1:0] ASI_AESSUB_DECROT = 5'b01_0_11;
    localparam logic [OPW-1:0] ASI_AESMIX_ENC    = 5'b01_1_00; // Forward column
    localparam logic [OPW-1:0] ASI_AESMIX_DEC    = 5'b01_1_01; // Inverse column

    // SHA-3 lane index functions
    localparam logic [OPW-1:0] ASI_SHA3_XY = 5'b11_0_00;
    localparam logic [OPW-1:0] ASI_SHA3_X1 = 5'b11_0_01;
    localparam logic [OPW-1:0] ASI_SHA3_X2 = 5'b11_0_10;
    localparam logic [OPW-1:0] ASI_SHA3_X4 = 5'b11_0_11;
    localparam logic [OPW-1:0] ASI_SHA3_YX = 5'b11_1_00;

    // SHA-256, low two bits go straight to the function select
    localparam logic [OPW-1:0] ASI_SHA256_S0 = 5'b10_0_00; // sigma0
    localparam logic [OPW-1:0] ASI_SHA256_S1 = 5'b10_0_01; // sigma1
    localparam logic [OPW-1:0] ASI_SHA256_S2 = 5'b10_0_10; // Sum0
    localparam logic [OPW-1:0] ASI_SHA256_S3 = 5'b10_0_11; // Sum1

    // ----------------------------------------------------------
    // Micro-op views
    // ----------------------------------------------------------

    // Same five bits, read as a whole code or split into fields
    typedef union packed {
        logic [OPW-1:0] code;   // Flat compare against the codes above
        struct packed {
            logic [1:0] cls;    // Operation class
            logic       mix;    // AES mix / sub
            logic [1:0] fn;     // Function select within class
        } f;
    } asi_uop_u;

endpackage

//--- asi_sha256.sv
// SHA-256 sigma and sum functions
module asi_sha256 import asi_pkg::*; (
    input  logic [XLEN-1:0] rs1,    // Gated source word
    input  logic [1:0]      ss,     // Function select
    output logic [XLEN-1:0] result
);

    // Rotate right by a fixed distance
    function automatic logic [XLEN-1:0] ror(input logic [XLEN-1:0] w, input int n);
        return (w >> n) | (w << (XLEN - n));
    endfunction

    logic [XLEN-1:0] sigma0, sigma1; // Message schedule
    logic [XLEN-1:0] sum0, sum1;     // Compression round

    assign sigma0 = ror(rs1, 7)  ^ ror(rs1, 18) ^ (rs1 >> 3);
    assign sigma1 = ror(rs1, 17) ^ ror(rs1, 19) ^ (rs1 >> 10);
    assign sum0   = ror(rs1, 2)  ^ ror(rs1, 13) ^ ror(rs1, 22);
    assign sum1   = ror(rs1, 6)  ^ ror(rs1, 11) ^ ror(rs1, 25);

    // Final select
    always_comb begin
        case (ss)
            2'd0:    result = sigma0;
            2'd1:    result = sigma1;
            2'd2:    result = sum0;
            default: result = sum1;
        endcase
    end

endmodule

//--- asi_sha3.sv
// SHA-3 lane index functions
module asi_sha3 import asi_pkg::*; (
    input  logic [XLEN-1:0] rs1,    // x coordinate in low byte
    input  logic [XLEN-1:0] rs2,    // y coordinate in low byte
    input  logic [1:0]      shamt,  // Post-shift amount
    input  logic            f_xy,
    input  logic            f_x1,
    input  logic            f_x2,
    input  logic            f_x4,
    input  logic            f_yx,
    output logic [XLEN-1:0] result
);

    // Sum of two residues, reduced mod 5
    function automatic logic [2:0] add_mod5(input logic [2:0] a, input logic [2:0] b);
        logic [3:0] s;
        s = {1'b0, a} + {1'b0, b};
        return (s >= 4'd5) ? 3'(s - 4'd5) : s[2:0];
    endfunction

    // Lane number col + 5*row, at most 24
    function automatic logic [4:0] lane(input logic [2:0] col, input logic [2:0] row);
        return 5'(col) + 5'(row) * 5'd5;
    endfunction

    logic [2:0] x, y;               // Coordinates, 0..4
    logic [2:0] x2_m, y3_m;         // 2x and 3y mod 5
    logic [4:0] idx;                // Selected lane index
    logic [7:0] idx_sh;             // After post-shift

    assign x = 3'(rs1[7:0] % 8'd5);
    assign y = 3'(rs2[7:0] % 8'd5);

    assign x2_m = add_mod5(x, x);
    assign y3_m = add_mod5(add_mod5(y, y), y);

    // One-hot AND-OR select, zero when no function is active
    assign idx = ({5{f_xy}} & lane(x, y))
               | ({5{f_x1}} & lane(add_mod5(x, 3'd1), y))
               | ({5{f_x2}} & lane(add_mod5(x, 3'd2), y))
               | ({5{f_x4}} & lane(add_mod5(x, 3'd4), y))
               | ({5{f_yx}} & lane(y, add_mod5(x2_m, y3_m)));  // Rho/pi walk

    assign idx_sh = 8'(idx) << shamt;                   // Max 24 << 3 fits a byte
    assign result = {{(XLEN - 8){1'b0}}, idx_sh};

    // Top-level decode compares exact codes, so at most one select
    always_comb begin
        assert final ($onehot0({f_xy, f_x1, f_x2, f_x4, f_yx}))
            else $error("asi_sha3: more than one function select high");
    end

endmodule

//--- build.f
+incdir+.
asi_pkg.sv
asi_sha256.sv
asi_sha3.sv
asi_aes_sbox.sv
asi_aes_sub.sv
asi_aes_mix.sv
frv_asi.sv
tb_frv_asi.sv

//--- frv_asi.sv
// Algorithm-specific instruction unit
module frv_asi import asi_pkg::*; (
    input  logic            g_clk,
    input  logic            rst_n,
    input  logic            asi_valid,  // Operation presented
    input  logic            asi_flush,  // Abandon the stage
    input  logic [OPW-1:0]  asi_uop,    // Exact operation
    input  logic [XLEN-1:0] asi_rs1,
    input  logic [XLEN-1:0] asi_rs2,
    input  logic [1:0]      asi_shamt,  // SHA-3 post-shift
    output logic            asi_ready,  // Result good this cycle
    output logic [XLEN-1:0] asi_result
);

    asi_uop_u uop;
    assign uop = asi_uop;

    // ----------------------------------------------------------
    // Decode
    // ----------------------------------------------------------

    // Group selects from the class field
    logic insn_aes, insn_aes_sub, insn_aes_mix, insn_sha2, insn_sha3;
    assign insn_aes     = asi_valid && uop.f.cls == ASI_AES;
    assign insn_aes_sub = insn_aes && !uop.f.mix;
    assign insn_aes_mix = insn_aes &&  uop.f.mix;
    assign insn_sha2    = asi_valid && uop.f.cls == ASI_SHA2;
    assign insn_sha3    = asi_valid && uop.f.cls == ASI_SHA3;

    // Exact operations from the flat code
    logic insn_aessub_encrot, insn_aessub_dec, insn_aessub_decrot, insn_aesmix_dec;
    logic insn_sha3_xy, insn_sha3_x1, insn_sha3_x2, insn_sha3_x4, insn_sha3_yx;
    assign insn_aessub_encrot = asi_valid && uop.code == ASI_AESSUB_ENCROT;
    assign insn_aessub_dec    = asi_valid && uop.code == ASI_AESSUB_DEC;
    assign insn_aessub_decrot = asi_valid && uop.code == ASI_AESSUB_DECROT;
    assign insn_aesmix_dec    = asi_valid && uop.code == ASI_AESMIX_DEC;
    assign insn_sha3_xy       = asi_valid && uop.code == ASI_SHA3_XY;
    assign insn_sha3_x1       = asi_valid && uop.code == ASI_SHA3_X1;
    assign insn_sha3_x2       = asi_valid && uop.code == ASI_SHA3_X2;
    assign insn_sha3_x4       = asi_valid && uop.code == ASI_SHA3_X4;
    assign insn_sha3_yx       = asi_valid && uop.code == ASI_SHA3_YX;

    // ----------------------------------------------------------
    // Units
    // ----------------------------------------------------------

    logic [XLEN-1:0] sha2_rs1;                  // Quiet unless SHA-2 active
    logic [XLEN-1:0] result_sha2, result_sha3, result_aessub, result_aesmix;
    logic            sub_done;

    assign sha2_rs1 = {XLEN{insn_sha2}} & asi_rs1;

    asi_sha3 i_sha3 (
        .rs1 (asi_rs1), .rs2 (asi_rs2), .shamt (asi_shamt),
        .f_xy (insn_sha3_xy), .f_x1 (insn_sha3_x1), .f_x2 (insn_sha3_x2),
        .f_x4 (insn_sha3_x4), .f_yx (insn_sha3_yx), .result (result_sha3)
    );

    asi_sha256 i_sha256 (.rs1 (sha2_rs1), .ss (uop.f.fn), .result (result_sha2));

    asi_aes_sub i_aes_sub (
        .g_clk (g_clk), .rst_n (rst_n), .start (insn_aes_sub),
        .inv (insn_aessub_dec || insn_aessub_decrot),
        .rot (insn_aessub_encrot || insn_aessub_decrot),
        .flush (asi_flush), .rs1 (asi_rs1), .done (sub_done), .result (result_aessub)
    );

    asi_aes_mix i_aes_mix (.col (asi_rs1), .inv (insn_aesmix_dec), .result (result_aesmix));

    // ----------------------------------------------------------
    // Result and handshake
    // ----------------------------------------------------------

    assign asi_result = ({XLEN{insn_aes_mix}} & result_aesmix)
                      | ({XLEN{insn_aes_sub}} & result_aessub)
                      | ({XLEN{insn_sha2}}    & result_sha2)
                      | ({XLEN{insn_sha3}}    & result_sha3);

    // All but SubBytes finish in the issue cycle
    assign asi_ready = !asi_flush &&
                       (insn_sha2 || insn_sha3 || insn_aes_mix || (insn_aes_sub && sub_done));

    logic uop_legal;
    assign uop_legal = uop.code inside {ASI_AESSUB_ENC, ASI_AESSUB_ENCROT, ASI_AESSUB_DEC,
        ASI_AESSUB_DECROT, ASI_AESMIX_ENC, ASI_AESMIX_DEC, ASI_SHA3_XY, ASI_SHA3_X1,
        ASI_SHA3_X2, ASI_SHA3_X4, ASI_SHA3_YX, ASI_SHA256_S0, ASI_SHA256_S1,
        ASI_SHA256_S2, ASI_SHA256_S3};

    assert property (@(posedge g_clk) disable iff (!rst_n) asi_valid |-> uop_legal)
        else $error("frv_asi: undefined micro-op");

    // Core holds operands until the engine strobes done
    assert property (@(posedge g_clk) disable iff (!rst_n)
        insn_aes_sub && !asi_ready && !asi_flush |=>
            asi_flush || (asi_valid && $stable(asi_rs1) && $stable(asi_uop)))
        else $error("frv_asi: operands changed during SubBytes");

    assert property (@(posedge g_clk) disable iff (!rst_n) asi_ready |-> asi_valid)
        else $error("frv_asi: ready without valid");

endmodule

//--- asi_ref.svh
// Instruction unit reference model
`ifndef ASI_REF_SVH
`define ASI_REF_SVH

logic [7:0] sbox_tab     [256];     // Forward S-box, filled at time 0
logic [7:0] inv_sbox_tab [256];     // Preimage of each forward entry

// ------------------------------------------------------------
// GF(2^8) and S-box tables
// ------------------------------------------------------------

function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] t;
    p = 8'h00;
    t = a;
    for (int i = 0; i < 8; i++) begin
        if (b[i]) p = p ^ t;
        t = {t[6:0], 1'b0} ^ (t[7] ? 8'h1b : 8'h00);   // Reduce by 0x11B
    end
    return p;
endfunction

// Exhaustive search, zero stays zero
function automatic logic [7:0] gf_inverse(input logic [7:0] a);
    logic [7:0] r;
    r = 8'h00;
    for (int b = 1; b < 256; b++) begin
        if (gf_mul(a, 8'(b)) == 8'h01) r = 8'(b);
    end
    return r;
endfunction

// Bitwise affine map from the AES definition
function automatic logic [7:0] affine_fwd(input logic [7:0] b);
    logic [7:0] s;
    for (int i = 0; i < 8; i++) begin
        s[i] = b[i] ^ b[(i + 4) % 8] ^ b[(i + 5) % 8] ^ b[(i + 6) % 8] ^ b[(i + 7) % 8];
    end
    return s ^ 8'h63;
endfunction

function automatic void build_sbox_tables();
    for (int a = 0; a < 256; a++) begin
        sbox_tab[a] = affine_fwd(gf_inverse(8'(a)));
        inv_sbox_tab[sbox_tab[a]] = 8'(a);         // Inverse table by lookup
    end
endfunction

// ------------------------------------------------------------
// Per-operation references
// ------------------------------------------------------------

function automatic logic [XLEN-1:0] rotr(input logic [XLEN-1:0] w, input int n);
    logic [2*XLEN-1:0] d;
    d = {w, w} >> n;
    return d[XLEN-1:0];
endfunction

function automatic logic [XLEN-1:0] sha256_ref(input logic [1:0] fn, input logic [XLEN-1:0] w);
    case (fn)
        2'd0:    return rotr(w, 7) ^ rotr(w, 18) ^ (w >> 3);
        2'd1:    return rotr(w, 17) ^ rotr(w, 19) ^ (w >> 10);
        2'd2:    return rotr(w, 2) ^ rotr(w, 13) ^ rotr(w, 22);
        default: return rotr(w, 6) ^ rotr(w, 11) ^ rotr(w, 25);
    endcase
endfunction

function automatic logic [XLEN-1:0] sha3_ref(input logic [OPW-1:0] code,
                                             input logic [XLEN-1:0] rs1,
                                             input logic [XLEN-1:0] rs2,
                                             input logic [1:0] shamt);
    int x;
    int y;
    int idx;
    x = int'(rs1[7:0]) % 5;
    y = int'(rs2[7:0]) % 5;
    case (code)
        ASI_SHA3_XY: idx = x + 5 * y;
        ASI_SHA3_X1: idx = (x + 1) % 5 + 5 * y;
        ASI_SHA3_X2: idx = (x + 2) % 5 + 5 * y;
        ASI_SHA3_X4: idx = (x + 4) % 5 + 5 * y;
        default:     idx = y + 5 * ((2 * x + 3 * y) % 5);
    endcase
    return XLEN'(idx << shamt);
endfunction

function automatic logic [XLEN-1:0] aes_sub_ref(input logic [XLEN-1:0] w, input logic inv,
                                                input logic rot);
    logic [XLEN-1:0] s;
    for (int i = 0; i < 4; i++) begin
        s[8*i +: 8] = inv ? inv_sbox_tab[w[8*i +: 8]] : sbox_tab[w[8*i +: 8]];
    end
    return rot ? {s[23:0], s[31:24]} : s;          // Byte rotate left
endfunction

// Row i of the matrix is row 0 rotated right by i
function automatic logic [XLEN-1:0] mix_ref(input logic [XLEN-1:0] col, input logic inv);
    logic [XLEN-1:0] coef;
    logic [XLEN-1:0] r;
    coef = inv ? 32'h090d0b0e : 32'h01010302;      // Row 0, byte k for column k
    r    = '0;
    for (int i = 0; i < 4; i++) begin
        for (int j = 0; j < 4; j++) begin
            r[8*i +: 8] = r[8*i +: 8] ^ gf_mul(coef[8*((j - i + 4) % 4) +: 8], col[8*j +: 8]);
        end
    end
    return r;
endfunction

// Expected result, keyed by micro-op
function automatic logic [XLEN-1:0] expected_result(input logic [OPW-1:0] uop,
                                                    input logic [XLEN-1:0] rs1,
                                                    input logic [XLEN-1:0] rs2,
                                                    input logic [1:0] shamt);
    asi_uop_u u;
    u = uop;
    if (u.f.cls == ASI_SHA2) return sha256_ref(u.f.fn, rs1);
    if (u.f.cls == ASI_SHA3) return sha3_ref(u.code, rs1, rs2, shamt);
    if (u.f.mix) return mix_ref(rs1, u.code == ASI_AESMIX_DEC);
    return aes_sub_ref(rs1, u.code inside {ASI_AESSUB_DEC, ASI_AESSUB_DECROT},
                       u.code inside {ASI_AESSUB_ENCROT, ASI_AESSUB_DECROT});
endfunction

`endif

//--- tb_frv_asi.sv
// Instruction unit testbench
module tb_frv_asi import asi_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 10;
    localparam int N_SHA2 = 200;    // Per SHA-256 function
    localparam int N_SHA3 = 40;     // Per index function
    localparam int N_SUB  = 25;     // Per SubBytes variant
    localparam int N_MIX  = 40;     // Forward and inverse pairs
    localparam int N_OPS  = 4 * N_SHA2 + 5 * N_SHA3 + 4 * N_SUB + 2 * N_MIX + 7;

    localparam logic [OPW-1:0] SHA2_OPS [4] = '{ASI_SHA256_S0, ASI_SHA256_S1,
                                                ASI_SHA256_S2, ASI_SHA256_S3};
    localparam logic [OPW-1:0] SHA3_OPS [5] = '{ASI_SHA3_XY, ASI_SHA3_X1, ASI_SHA3_X2,
                                                ASI_SHA3_X4, ASI_SHA3_YX};
    localparam logic [OPW-1:0] SUB_OPS  [4] = '{ASI_AESSUB_ENC, ASI_AESSUB_ENCROT,
                                                ASI_AESSUB_DEC, ASI_AESSUB_DECROT};

    logic            g_clk;
    logic            rst_n;
    logic            asi_valid;
    logic            asi_flush;
    logic [OPW-1:0]  asi_uop;
    logic [XLEN-1:0] asi_rs1;
    logic [XLEN-1:0] asi_rs2;
    logic [1:0]      asi_shamt;
    logic            asi_ready;
    logic [XLEN-1:0] asi_result;
    string           test_name;     // Follows the op on the inputs

    `include "asi_ref.svh"

    frv_asi i_dut (
        .g_clk (g_clk), .rst_n (rst_n), .asi_valid (asi_valid), .asi_flush (asi_flush),
        .asi_uop (asi_uop), .asi_rs1 (asi_rs1), .asi_rs2 (asi_rs2), .asi_shamt (asi_shamt),
        .asi_ready (asi_ready), .asi_result (asi_result)
    );

    initial begin
        g_clk = 1'b0;
        forever #(CLK_PERIOD / 2) g_clk = ~g_clk;
    end

    // ----------------------------------------------------------
    // Error exits
    // ----------------------------------------------------------

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [XLEN-1:0] exp_val,
                                   input logic [XLEN-1:0] act_val);
        stop_on_error($sformatf("Mismatch %s expected %08h actual %08h", name, exp_val, act_val));
    endtask

    // ----------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------

    // Present one op, hold it until ready, check latency
    task automatic run_op(input string name, input logic [OPW-1:0] uop,
                          input logic [XLEN-1:0] rs1, input logic [XLEN-1:0] rs2,
                          input logic [1:0] shamt, input int exp_lat,
                          output logic [XLEN-1:0] got);
        int lat;
        test_name <= name;
        asi_valid <= 1'b1;
        asi_uop   <= uop;
        asi_rs1   <= rs1;
        asi_rs2   <= rs2;
        asi_shamt <= shamt;
        lat = 0;
        do begin
            @(posedge g_clk);
            lat++;
        end while (!asi_ready);
        got = asi_result;                   // Still the issued op's result
        assert (lat - 1 == exp_lat)
            else report_mismatch({name, " latency"}, XLEN'(exp_lat), XLEN'(lat - 1));
    endtask

    task automatic random_ops(input logic [OPW-1:0] uop, input int count, input int exp_lat);
        logic [XLEN-1:0] got;
        for (int i = 0; i < count; i++) begin
            run_op($sformatf("op %05b", uop), uop, $urandom(), $urandom(), 2'($urandom()),
                   exp_lat, got);
        end
    endtask

    // Abandon a SubBytes op mid-flight, then run a fresh one
    task automatic check_flush();
        logic [XLEN-1:0] got;
        test_name <= "flushed aes sub";
        asi_valid <= 1'b1;
        asi_uop   <= ASI_AESSUB_ENC;
        asi_rs1   <= $urandom();
        @(posedge g_clk);                   // Engine on byte 1
        asi_flush <= 1'b1;
        @(posedge g_clk);
        assert (!asi_ready) else stop_on_error("asi_ready high in a flush cycle");
        asi_flush <= 1'b0;                  // New op issued straight after the flush
        run_op("aes sub after flush", ASI_AESSUB_ENC, $urandom(), '0, 2'd0,
               AES_SUB_CYCLES, got);
    endtask

    // ----------------------------------------------------------
    // Compare and watchdog
    // ----------------------------------------------------------

    always @(posedge g_clk) begin
        logic [XLEN-1:0] exp_val;
        if (asi_valid && asi_ready) begin
            exp_val = expected_result(asi_uop, asi_rs1, asi_rs2, asi_shamt);
            assert (asi_result === exp_val) else report_mismatch(test_name, exp_val, asi_result);
        end
    end

    initial begin
        #((N_OPS * (AES_SUB_CYCLES + 4) + 50) * CLK_PERIOD);
        stop_on_error("Timeout: the DUT never became ready");
    end

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------

    initial begin
        logic [XLEN-1:0] got;
        logic [XLEN-1:0] col;
        logic [XLEN-1:0] back;
        void'($urandom(32'hd394_836a));
        build_sbox_tables();
        rst_n     = 1'b0;
        asi_valid = 1'b0;
        asi_flush = 1'b0;
        asi_uop   = ASI_SHA256_S0;
        asi_rs1   = '0;
        asi_rs2   = '0;
        asi_shamt = 2'd0;
        test_name = "reset";
        repeat (2) begin
            @(posedge g_clk);
            assert (!asi_ready) else stop_on_error("asi_ready high during reset");
        end
        rst_n <= 1'b1;
        @(posedge g_clk);
        assert (!asi_ready) else stop_on_error("asi_ready high after reset without asi_valid");

        for (int k = 0; k < 4; k++) random_ops(SHA2_OPS[k], N_SHA2, 0);
        for (int k = 0; k < 5; k++) random_ops(SHA3_OPS[k], N_SHA3, 0);
        for (int k = 0; k < 4; k++) random_ops(SUB_OPS[k], N_SUB, AES_SUB_CYCLES);

        run_op("aes sub zero", ASI_AESSUB_ENC, '0, '0, 2'd0, AES_SUB_CYCLES, got);
        assert (got == 32'h6363_6363) else report_mismatch("aes sub zero", 32'h6363_6363, got);

        // Forward then inverse must give the column back
        for (int i = 0; i < N_MIX; i++) begin
            col = $urandom();
            run_op("aes mix fwd", ASI_AESMIX_ENC, col, '0, 2'd0, 0, got);
            run_op("aes mix inv", ASI_AESMIX_DEC, got, '0, 2'd0, 0, back);
            assert (back == col) else report_mismatch("aes mix roundtrip", col, back);
        end
        run_op("aes mix vector", ASI_AESMIX_ENC, 32'h4553_13db, '0, 2'd0, 0, got);
        assert (got == 32'hbca1_4d8e) else report_mismatch("aes mix vector", 32'hbca1_4d8e, got);

        check_flush();

        asi_valid <= 1'b0;
        @(posedge g_clk);
        $display("TESTS PASSED");
        $finish;
    end

endmodule
